// ==== testbench/bridge_stimulus.txt ====
# W <host word hex> | B <chip word hex> <expected low hex> <expected high hex>
# R <host reads> | N <idle cycles>
W 0512345A
B 2ABCDEF01 01CDEF01 020002AB
N 4
W 9F000000
W 01000001
W 3F0FFFFF
W 12ABCDE0
W 2A055555
B 2ABCDEF01 01CDEF01 020002AB
B 155AA33CC 01AA33CC 02000155
B 3FFFFFFFF 01FFFFFF 020003FF
R 6
W C5001234
W FF00BEEF
W 4A000077
W 85000007
N 6
W 07000100
W 08000200
W 9F000001
W 09000300
N 5
W 9F000000
W 0A000400
W 0B000500
N 8

// ==== filelist.f ====
source/bdHostPkg.sv
source/regWriteIf.sv
source/wordFifo.sv
source/hostWordDecoder.sv
source/configRegs.sv
source/upstreamPacker.sv
source/bdHostBridge.sv
testbench/bdHostBridge_assertions.sv
testbench/bdHostBridge_tb.sv

// ==== Bender.yml ====
package:
  name: bd_host_bridge

sources:
  - files:
      - source/bdHostPkg.sv
      - source/regWriteIf.sv
      - source/wordFifo.sv
      - source/hostWordDecoder.sv
      - source/configRegs.sv
      - source/upstreamPacker.sv
      - source/bdHostBridge.sv
  - target: test
    files:
      - testbench/bdHostBridge_assertions.sv
      - testbench/bdHostBridge_tb.sv

// ==== testbench/bdHostBridge_tb.sv ====
`timescale 1ns/100ps

module bdHostBridge_tb;

  localparam string stimFile  = "testbench/bridge_stimulus.txt";
  localparam int    fifoDepth = 8;  // Both DUT FIFOs

  logic                                clk;
  logic                                rstN;
  logic                                pipeInValid;
  logic [bdHostPkg::hostWordW-1:0]     pipeInData;
  logic                                pipeInFull;
  logic                                pipeOutRead;
  logic [bdHostPkg::hostWordW-1:0]     pipeOutData;
  logic                                pipeOutEmpty;
  logic                                bdOutValid;
  logic                                bdOutReady;
  bdHostPkg::bdWordT                   bdOutData;
  logic                                bdInValid;
  logic                                bdInReady;
  logic [bdHostPkg::upWordW-1:0]       bdInData;
  logic                                chanValid;
  logic [bdHostPkg::regIdW-1:0]        chanId;
  logic [bdHostPkg::regDataW-1:0]      chanData;

  bdHostPkg::bdWordT               expDown[$];  // Words the chip should see in order
  logic [bdHostPkg::hostWordW-1:0] expUp[$];    // Host words the pipe should deliver
  logic                            downHeld = 1'b1;  // Model of the path resets
  logic                            upHeld   = 1'b1;
  logic [31:0]                     lfsr     = 32'h8806;
  int                              cycleCount = 0;
  int                              cycleLimit = 0;

  bdHostBridge #(.downDepth(fifoDepth), .upDepth(fifoDepth)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic logic takeBit();  // Galois LFSR stepped once per bit
    logic out;
    out  = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    return out;
  endfunction

  task automatic failRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic nextCycle();  // Inputs change 2 ns after the edge
    @(posedge clk);
    #2;
  endtask

  task automatic requireFields(input int got, input int want, input byte cmd);
    if (got != want) begin
      $display("Stimulus line for command %c is missing fields", cmd);
      failRun();
    end
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, actual, expected);
      failRun();
    end
  endtask

  task automatic checkBdWord(input bdHostPkg::bdWordT actual,
                             input bdHostPkg::bdWordT expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: bdOutData got %h expected %h", $time, actual, expected);
      failRun();
    end
  endtask

  task automatic checkHostWord(input logic [bdHostPkg::hostWordW-1:0] actual,
                               input logic [bdHostPkg::hostWordW-1:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: pipeOutData got %h expected %h", $time, actual, expected);
      failRun();
    end
  endtask

  task automatic checkChan(input logic [bdHostPkg::regIdW-1:0] id,
                           input logic [bdHostPkg::regDataW-1:0] data,
                           input logic [bdHostPkg::regIdW-1:0] expId,
                           input logic [bdHostPkg::regDataW-1:0] expData);
    if (id !== expId) begin
      $display("FAILED at %0t ns: chanId got %h expected %h", $time, id, expId);
      failRun();
    end
    if (data !== expData) begin
      $display("FAILED at %0t ns: chanData got %h expected %h", $time, data, expData);
      failRun();
    end
  endtask

  // ------------------------------------------------------------------------
  // Commands
  // ------------------------------------------------------------------------
  task automatic hostWrite(input logic [31:0] word);
    bdHostPkg::hostKindT kind;
    bdHostPkg::bdWordT   expWord;
    kind            = bdHostPkg::hostKindT'(word[31:30]);
    expWord.code    = word[29:24];
    expWord.payload = word[19:0];
    if (expDown.size() + 1 < fifoDepth)
      checkBit("pipeInFull", pipeInFull, 1'b0);  // Room left for this word
    pipeInData      = word;
    pipeInValid     = 1'b1;
    if (kind == bdHostPkg::kindBd && !downHeld)
      expDown.push_back(expWord);  // Dropped by the flush while held
    nextCycle();
    pipeInValid = 1'b0;
    checkBit("chanValid", chanValid, kind == bdHostPkg::kindChan);  // Decoder lags one cycle
    if (kind == bdHostPkg::kindChan)
      checkChan(chanId, chanData, word[28:24], word[15:0]);
    if (kind == bdHostPkg::kindReg && word[28:24] == bdHostPkg::resetRegId) begin
      repeat (2) nextCycle();  // Reset levels follow 2 cycles after the strobe
      downHeld = word[0];
      upHeld   = word[1];
      if (downHeld)
        expDown.delete();      // Whatever did not reach the chip is flushed
    end
  endtask

  task automatic chipWrite(input logic [33:0] word, input logic [31:0] expLow,
                           input logic [31:0] expHigh);
    int gap;
    gap = 2 * takeBit();
    gap = gap + takeBit();
    repeat (gap) nextCycle();  // Random spacing of 0 to 3 cycles
    bdInData  = word;
    bdInValid = 1'b1;
    if (upHeld) begin
      repeat (8) nextCycle();  // Held path never takes it
    end else begin
      while (!bdInReady)
        nextCycle();
      expUp.push_back(expLow);
      expUp.push_back(expHigh);
      nextCycle();
    end
    bdInValid = 1'b0;
  endtask

  task automatic hostRead(input int count);
    repeat (count) begin
      while (pipeOutEmpty)
        nextCycle();
      if (expUp.size() == 0) begin
        $display("Host word at %0t ns arrived with none expected", $time);
        failRun();
      end
      checkHostWord(pipeOutData, expUp.pop_front());
      pipeOutRead = 1'b1;
      nextCycle();
      pipeOutRead = 1'b0;
    end
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      nextCycle();
      checkBit("chanValid", chanValid, 1'b0);  // No stray channel pulses
    end
  endtask

  // ------------------------------------------------------------------------
  // Monitors
  // ------------------------------------------------------------------------
  initial begin
    logic readyBit;
    forever begin
      @(posedge clk);
      #1;                        // Own slot for the draw, apart from the gaps
      if (rstN) begin
        readyBit = takeBit();
        #1;
        bdOutReady = readyBit;   // Random chip back-pressure
        if (bdOutValid && bdOutReady) begin
          if (expDown.size() == 0) begin
            $display("Chip word %h at %0t ns with none expected", bdOutData, $time);
            failRun();
          end else begin
            checkBdWord(bdOutData, expDown.pop_front());
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    if (rstN) begin
      if (downHeld && bdOutValid) begin
        $display("bdOutValid rose at %0t ns while the downstream reset is set", $time);
        failRun();
      end
      if (upHeld && (bdInReady || !pipeOutEmpty)) begin
        $display("Upstream path moved at %0t ns while its reset is set", $time);
        failRun();
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, the bridge stopped responding", cycleCount);
      failRun();
    end
  end

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    int          fd;
    int          code;
    int          count;
    int          lineCount;
    byte         cmd;
    string       line;
    logic [31:0] word;
    logic [31:0] expLow;
    logic [31:0] expHigh;
    logic [33:0] chipWord;
    rstN        = 1'b0;
    pipeInValid = 1'b0;
    pipeInData  = '0;
    pipeOutRead = 1'b0;
    bdOutReady  = 1'b0;
    bdInValid   = 1'b0;
    bdInData    = '0;
    lineCount   = 0;
    fd = $fopen(stimFile, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", stimFile);
      failRun();
    end
    while ($fgets(line, fd) != 0)
      lineCount++;
    $fclose(fd);
    cycleLimit = 20 * lineCount + 200;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    fd = $fopen(stimFile, "r");
    while ($fscanf(fd, " %c", cmd) == 1) begin
      if (cmd == "#") begin
        code = $fgets(line, fd);  // Comment line
      end else if (cmd == "W") begin
        code = $fscanf(fd, " %h", word);
        requireFields(code, 1, cmd);
        hostWrite(word);
      end else if (cmd == "B") begin
        code = $fscanf(fd, " %h %h %h", chipWord, expLow, expHigh);
        requireFields(code, 3, cmd);
        chipWrite(chipWord, expLow, expHigh);
      end else if (cmd == "R") begin
        code = $fscanf(fd, " %d", count);
        requireFields(code, 1, cmd);
        hostRead(count);
      end else if (cmd == "N") begin
        code = $fscanf(fd, " %d", count);
        requireFields(code, 1, cmd);
        idleCycles(count);
      end else begin
        $display("Unknown command '%c' in the stimulus file", cmd);
        failRun();
      end
    end
    $fclose(fd);
    while (expDown.size() != 0)
      nextCycle();  // Let the chip drain what is still queued
    idleCycles(2);
    checkBit("pipeOutEmpty", pipeOutEmpty, 1'b1);  // No host words beyond the expected
    if (expUp.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("%0d host words were never read", expUp.size());
      failRun();
    end
  end

endmodule

// ==== testbench/bdHostBridge_assertions.sv ====
`timescale 1ns/100ps

// Handshake and reset rules of the bridge ports
module bdHostBridge_assertions (
  input logic              clk,
  input logic              rstN,
  input logic              bdOutValid,
  input logic              bdOutReady,
  input bdHostPkg::bdWordT bdOutData,
  input logic              bdInReady,
  input logic              downReset,
  input logic              upReset,
  input logic              pipeInValid,
  input logic              chanValid
);

  // Valid holds with stable data until taken, unless the path is flushed
  assert property (@(posedge clk) disable iff (!rstN)
    bdOutValid && !bdOutReady |=> downReset || (bdOutValid && $stable(bdOutData)))
    else $error("bdOutValid or bdOutData changed before a transfer");

  assert property (@(posedge clk) disable iff (!rstN)
    upReset |-> !bdInReady)
    else $error("bdInReady high while the upstream reset is set");

  assert property (@(posedge clk) disable iff (!rstN)
    chanValid |-> $past(pipeInValid))  // Decoder delay is one cycle
    else $error("chanValid pulse without an inbound host word");

endmodule

bind bdHostBridge bdHostBridge_assertions checks (.*);

// ==== source/bdHostBridge.sv ====
`timescale 1ns/100ps

// Host pipe to neuromorphic chip bridge, single clock
module bdHostBridge #(
  parameter int downDepth = 8,  // Downstream FIFO depth
  parameter int upDepth   = 8   // Upstream FIFO depth, 2 or more
) (
  input  logic                                clk,
  input  logic                                rstN,
  // Host pipe in
  input  logic                                pipeInValid,
  input  logic [bdHostPkg::hostWordW-1:0]     pipeInData,
  output logic                                pipeInFull,
  // Host pipe out
  input  logic                                pipeOutRead,
  output logic [bdHostPkg::hostWordW-1:0]     pipeOutData,
  output logic                                pipeOutEmpty,
  // Chip out
  output logic                                bdOutValid,
  input  logic                                bdOutReady,
  output bdHostPkg::bdWordT                   bdOutData,
  // Chip in
  input  logic                                bdInValid,
  output logic                                bdInReady,
  input  logic [bdHostPkg::upWordW-1:0]       bdInData,
  // Channel writes
  output logic                                chanValid,
  output logic [bdHostPkg::regIdW-1:0]        chanId,
  output logic [bdHostPkg::regDataW-1:0]      chanData
);

  regWriteIf regWr ();

  logic                              downWrite;
  bdHostPkg::bdWordT                 downWord;
  logic                              downEmpty;
  logic                              downReset, upReset;
  logic                              upWrite;
  logic [bdHostPkg::hostWordW-1:0]   upData;
  logic [$clog2(upDepth+1)-1:0]      upFree;

  // ------------------------------------------------------------------------
  // Inbound side
  // ------------------------------------------------------------------------
  hostWordDecoder decoder (
    .clk, .rstN,
    .pipeInValid, .pipeInData,
    .regWr     (regWr.source),
    .downWrite, .downWord,
    .chanValid, .chanId, .chanData
  );

  configRegs regs (
    .clk, .rstN,
    .regWr     (regWr.sink),
    .downReset, .upReset
  );

  assign bdOutValid = !downEmpty;  // Head word ready for the chip

  wordFifo #(.width($bits(bdHostPkg::bdWordT)), .depth(downDepth)) downFifo (
    .clk, .rstN,
    .flush     (downReset),
    .write     (downWrite),
    .writeData (downWord),
    .read      (bdOutValid && bdOutReady),  // Pop on transfer
    .readData  (bdOutData),
    .empty     (downEmpty),
    .full      (pipeInFull),
    .freeCount ()
  );

  // ------------------------------------------------------------------------
  // Outbound side
  // ------------------------------------------------------------------------
  upstreamPacker #(.depth(upDepth)) packer (
    .clk, .rstN,
    .hold      (upReset),
    .bdInValid, .bdInReady, .bdInData,
    .freeCount (upFree),
    .fifoWrite (upWrite),
    .fifoData  (upData)
  );

  wordFifo #(.width(bdHostPkg::hostWordW), .depth(upDepth)) upFifo (
    .clk, .rstN,
    .flush     (upReset),
    .write     (upWrite),
    .writeData (upData),
    .read      (pipeOutRead),
    .readData  (pipeOutData),
    .empty     (pipeOutEmpty),
    .full      (),              // Packer watches freeCount instead
    .freeCount (upFree)
  );

endmodule

// ==== source/upstreamPacker.sv ====
`timescale 1ns/100ps

// Turns one chip word into a low and a high tagged host word
module upstreamPacker #(
  parameter int depth = 8  // Upstream FIFO depth, sizes freeCount
) (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              hold,       // Upstream reset
  input  logic                              bdInValid,
  output logic                              bdInReady,
  input  logic [bdHostPkg::upWordW-1:0]     bdInData,
  input  logic [$clog2(depth+1)-1:0]        freeCount,  // Space left in the FIFO
  output logic                              fifoWrite,
  output logic [bdHostPkg::hostWordW-1:0]   fifoData
);

  localparam int cntW  = $clog2(depth + 1);
  localparam int highW = bdHostPkg::upWordW - bdHostPkg::upLowW;  // 10 bits
  localparam int padW  = bdHostPkg::hostWordW - $bits(bdHostPkg::upTagT) - highW;

  typedef enum logic {
    stIdle,   // Waiting for a chip word
    stHigh    // Low word issued, high word next
  } stateT;

  stateT            state;
  logic [highW-1:0] highBits;  // Upper chip bits, kept for the second word
  logic             accept;

  // No new word until both halves are in the FIFO
  assign bdInReady = (state == stIdle) && !fifoWrite && !hold &&
                     (freeCount >= cntW'(2));
  assign accept    = bdInValid && bdInReady;

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN || hold) begin
      state     <= stIdle;
      fifoWrite <= 1'b0;
    end else begin
      fifoWrite <= 1'b0;
      case (state)
        stIdle: begin
          if (accept) begin
            state     <= stHigh;
            fifoWrite <= 1'b1;  // Low word
          end
        end
        stHigh: begin
          state     <= stIdle;
          fifoWrite <= 1'b1;    // High word
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (accept) begin
      highBits <= bdInData[bdHostPkg::upWordW-1:bdHostPkg::upLowW];
      fifoData <= {bdHostPkg::tagLow, bdInData[bdHostPkg::upLowW-1:0]};
    end else if (state == stHigh) begin
      fifoData <= {bdHostPkg::tagHigh, {padW{1'b0}}, highBits};  // Zero padded
    end
  end

endmodule

// ==== source/configRegs.sv ====
`timescale 1ns/100ps

// Configuration register bank, source of the path resets
module configRegs (
  input  logic    clk,
  input  logic    rstN,
  regWriteIf.sink regWr,
  output logic    downReset,  // Flushes downstream path
  output logic    upReset     // Flushes upstream path
);

  logic [bdHostPkg::regDataW-1:0] regs [bdHostPkg::numRegs];
  logic                           regWrite;

  // Channel writes pass by the bank
  assign regWrite = regWr.valid && !regWr.isChan;

  // ------------------------------------------------------------------------
  // Register array
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < bdHostPkg::numRegs; i++) begin
        if (i == bdHostPkg::resetRegId)
          regs[i] <= bdHostPkg::regDataW'(3);  // Both paths held
        else
          regs[i] <= '0;
      end
    end else if (regWrite) begin
      regs[regWr.addr] <= regWr.data;  // Unused ids just store, acts as nop
    end
  end

  // Reset levels
  always_ff @(posedge clk) begin
    if (!rstN) begin
      downReset <= 1'b1;
      upReset   <= 1'b1;
    end else begin
      downReset <= regs[bdHostPkg::resetRegId][0];
      upReset   <= regs[bdHostPkg::resetRegId][1];
    end
  end

endmodule

// ==== source/hostWordDecoder.sv ====
`timescale 1ns/100ps

// Splits the inbound host stream by word kind
module hostWordDecoder (
  input  logic                                 clk,
  input  logic                                 rstN,
  input  logic                                 pipeInValid,
  input  logic [bdHostPkg::hostWordW-1:0]      pipeInData,
  regWriteIf.source                            regWr,
  output logic                                 downWrite,   // Push into downstream FIFO
  output bdHostPkg::bdWordT                    downWord,
  output logic                                 chanValid,   // One-cycle pulse
  output logic [bdHostPkg::regIdW-1:0]         chanId,
  output logic [bdHostPkg::regDataW-1:0]       chanData
);

  bdHostPkg::hostKindT kind;

  logic                             regValid;
  logic                             regIsChan;
  logic [bdHostPkg::regIdW-1:0]     fieldId;   // Shared by register and channel writes
  logic [bdHostPkg::regDataW-1:0]   fieldData;

  // Kind lives in the top two bits
  assign kind = bdHostPkg::hostKindT'(
    pipeInData[bdHostPkg::hostWordW-1 -: $bits(bdHostPkg::hostKindT)]);

  // ------------------------------------------------------------------------
  // Strobes, cleared by reset
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      downWrite <= 1'b0;
      regValid  <= 1'b0;
      regIsChan <= 1'b0;
      chanValid <= 1'b0;
    end else begin
      downWrite <= pipeInValid && (kind == bdHostPkg::kindBd);
      // Register and channel writes both strobe the interface
      regValid  <= pipeInValid &&
                   ((kind == bdHostPkg::kindReg) || (kind == bdHostPkg::kindChan));
      regIsChan <= (kind == bdHostPkg::kindChan);
      chanValid <= pipeInValid && (kind == bdHostPkg::kindChan);
      // kindNone falls through, nothing fires
    end
  end

  // ------------------------------------------------------------------------
  // Field capture
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pipeInValid) begin
      downWord.code    <= pipeInData[bdHostPkg::codeLsb +: bdHostPkg::codeW];
      downWord.payload <= pipeInData[bdHostPkg::payloadW-1:0];
      fieldId          <= pipeInData[bdHostPkg::fieldLsb +: bdHostPkg::regIdW];
      fieldData        <= pipeInData[bdHostPkg::regDataW-1:0];
    end
  end

  assign regWr.valid  = regValid;
  assign regWr.isChan = regIsChan;
  assign regWr.addr   = fieldId;
  assign regWr.data   = fieldData;

  assign chanId   = fieldId;    // Channel sideband mirrors the write fields
  assign chanData = fieldData;

endmodule

// ==== source/wordFifo.sv ====
`timescale 1ns/100ps

// First-word-fall-through circular buffer
module wordFifo #(
  parameter int width = 32,
  parameter int depth = 8
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       flush,      // Empties the buffer
  input  logic                       write,
  input  logic [width-1:0]           writeData,
  input  logic                       read,
  output logic [width-1:0]           readData,   // Head word, valid while not empty
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(depth+1)-1:0] freeCount
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptrW-1:0]  wrPtr, rdPtr;
  logic [cntW-1:0]  count;
  logic             doWrite, doRead;

  assign empty     = (count == '0) || flush;  // Flushing looks empty at once
  assign full      = (count == cntW'(depth));
  assign freeCount = cntW'(depth) - count;
  assign readData  = mem[rdPtr];

  assign doWrite = write && !full && !flush;  // Dropped when full
  assign doRead  = read && !empty;

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite)
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;  // Wrap for any depth
      if (doRead)
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      if (doWrite && !doRead)
        count <= count + 1'b1;
      else if (doRead && !doWrite)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (doWrite)
      mem[wrPtr] <= writeData;
  end

endmodule

// ==== source/regWriteIf.sv ====
`timescale 1ns/100ps

// Decoded register or channel write, one-cycle strobe, no back-pressure
interface regWriteIf;

  logic                           valid;   // Strobe
  logic                           isChan;  // Channel write, not a register
  logic [bdHostPkg::regIdW-1:0]   addr;    // Register or channel id
  logic [bdHostPkg::regDataW-1:0] data;

  modport source (
    output valid, isChan, addr, data
  );

  modport sink (
    input valid, isChan, addr, data
  );

endinterface

// ==== source/bdHostPkg.sv ====
package bdHostPkg;

  // ------------------------------------------------------------------------
  // Host word geometry
  // ------------------------------------------------------------------------
  localparam int hostWordW = 32;  // Pipe word, both directions
  localparam int upWordW   = 34;  // Chip word coming up from the chip
  localparam int upLowW    = 24;  // Chip bits carried by the low host word

  localparam int codeW    = 6;    // Leaf code of a downstream word
  localparam int payloadW = 20;
  localparam int codeLsb  = 24;   // Code sits right under the kind bits
  localparam int fieldLsb = 24;   // Register or channel id, same spot

  // Configuration registers
  localparam int regIdW     = 5;
  localparam int regDataW   = 16;
  localparam int numRegs    = 32;
  localparam int resetRegId = 31; // Bit 0 downstream reset, bit 1 upstream reset

  // Top two bits of an inbound host word
  typedef enum logic [1:0] {
    kindBd   = 2'b00,  // Word for the chip
    kindNone = 2'b01,  // Ignored
    kindReg  = 2'b10,  // Config register write
    kindChan = 2'b11   // Channel write, pulsed out
  } hostKindT;

  // Header byte of an upstream host word
  typedef enum logic [7:0] {
    tagLow  = 8'h01,   // Chip bits 23..0
    tagHigh = 8'h02    // Chip bits 33..24
  } upTagT;

  // Downstream chip word, code on top
  typedef struct packed {
    logic [codeW-1:0]    code;
    logic [payloadW-1:0] payload;
  } bdWordT;

endpackage
